/* pattern_recognition.f */
design/vision_pkg.sv
design/pixel_stream_if.sv
design/line_window.sv
design/convolution_filter.sv
design/frame_capture.sv
design/pattern_recognition.sv
tests/tb_pattern_recognition.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := tb_pattern_recognition
FLIST     := pattern_recognition.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FLIST))

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/tb_pattern_recognition.sv */
`timescale 1ns/1ps

module tb_pattern_recognition;

    localparam int IW = 12;
    localparam int IH = 6;
    localparam int FRAMES = 6;
    localparam int IN_PIX = IW * IH;
    localparam int OUT_PIX = (IW - 2) * (IH - 2);
    localparam int LIMIT = FRAMES * IW * IH * 8 + 2000;

    logic              clk = 1'b0;
    logic              rst;
    logic              x_valid, x_ready, x_last;
    logic [7:0]        x_data;
    logic              y_valid, y_ready, y_last;
    logic [7:0]        y_data;
    logic signed [7:0] kernel [0:8];
    logic              capture_trigger, capture_complete, capturing;
    logic [5:0]        white_count;
    logic              crossing_detected, detection_valid;
    logic              wb_cyc, wb_stb, wb_ack;
    logic [6:0]        wb_adr;
    logic [7:0]        wb_rdata;

    logic [31:0] lfsr = 32'he3c1df71;
    int in_px [0:FRAMES-1][0:IN_PIX-1];
    int kern [0:FRAMES-1][0:8];
    int exp_pix [0:FRAMES-1][0:OUT_PIX-1];
    int exp_white [0:FRAMES-1];
    int errors = 0;
    int out_frame = 0;
    int out_idx = 0;
    int cap_frame = -1;
    int cap_done = 0;
    logic trig_q = 1'b0;

    pattern_recognition #(
        .IMG_WIDTH(IW), .IMG_HEIGHT(IH), .W(8), .W_FRAC(2),
        .WHITE_THRESH(128), .MIN_WHITE(10)
    ) DUT (.*);

    always #4 clk = !clk;

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v = {v[30:0], fb};
        end
        return v;
    endfunction

    // Frame setup with reference convolution and white count
    task automatic make_frame(input int f);
        int acc;
        int v;
        for (int t = 0; t < 9; t++) begin
            v = int'(take_bits(4));
            kern[f][t] = (v >= 8) ? v - 16 : v;
        end
        for (int i = 0; i < IN_PIX; i++) in_px[f][i] = int'(take_bits(8));
        exp_white[f] = 0;
        for (int r = 1; r < IH - 1; r++) begin
            for (int c = 1; c < IW - 1; c++) begin
                acc = 0;
                for (int t = 0; t < 9; t++)
                    acc += kern[f][t] * in_px[f][(r - 1 + t / 3) * IW + c - 1 + t % 3];
                acc = acc >>> 2;
                if (acc < 0) acc = -acc;
                if (acc > 255) acc = 255;
                exp_pix[f][(r - 1) * (IW - 2) + c - 1] = acc;
                if (acc >= 128) exp_white[f]++;
            end
        end
    endtask

    task automatic drive_frame(input int f, input bit trig);
        for (int t = 0; t < 9; t++) kernel[t] <= 8'(kern[f][t]);
        for (int i = 0; i < IN_PIX; i++) begin
            // Random input gaps
            while (take_bits(2) == 0) begin
                x_valid <= 1'b0;
                @(posedge clk);
            end
            x_valid <= 1'b1;
            x_data  <= 8'(in_px[f][i]);
            x_last  <= (i == IN_PIX - 1);
            capture_trigger <= trig && (i == 36);
            if (trig && i == 36) cap_frame = f + 1;
            do @(posedge clk); while (!x_ready);
        end
        capture_trigger <= 1'b0;
    endtask

    task automatic wb_read(input logic [6:0] adr, input logic [7:0] expv);
        int waited;
        waited = 0;
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_adr <= adr;
        do begin
            @(posedge clk);
            waited++;
        end while (!wb_ack && waited < 10);
        if (!wb_ack) begin
            $display("Wishbone read of address %0d never got an ack", adr);
            errors++;
        end else if (wb_rdata !== expv) begin
            $display("FAIL wb_rdata adr %h: got %h expected %h", adr, wb_rdata, expv);
            errors++;
        end
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        @(posedge clk);
        if (wb_ack) begin
            $display("Wishbone ack lasted more than one cycle at address %0d", adr);
            errors++;
        end
    endtask

    // Random output stalls, mostly ready
    always @(posedge clk) y_ready <= rst ? 1'b0 : (take_bits(2) != 0);

    // ========================================
    // Output and capture monitor
    // ========================================
    always @(posedge clk) begin
        if (!rst) begin
            if (trig_q && detection_valid) begin
                $display("detection_valid stayed high after a trigger");
                errors++;
            end
            if (capture_complete) begin
                cap_done++;
                if (out_frame != cap_frame + 1) begin
                    $display("capture_complete pulsed at the wrong frame");
                    errors++;
                end else if (white_count !== 6'(exp_white[cap_frame])) begin
                    $display("FAIL white_count: got %h expected %h",
                             white_count, 6'(exp_white[cap_frame]));
                    errors++;
                end
                if (crossing_detected !== (exp_white[cap_frame] >= 10)) begin
                    $display("FAIL crossing_detected: got %h expected %h",
                             crossing_detected, exp_white[cap_frame] >= 10);
                    errors++;
                end
                if (!detection_valid) begin
                    $display("detection_valid not raised with capture_complete");
                    errors++;
                end
            end
            if (y_valid && y_ready) begin
                if (out_frame >= FRAMES) begin
                    $display("Edge stream produced more pixels than expected");
                    errors++;
                end else begin
                    if (y_data !== 8'(exp_pix[out_frame][out_idx])) begin
                        $display("FAIL y_data frame %0d idx %0d: got %h expected %h",
                                 out_frame, out_idx, y_data,
                                 8'(exp_pix[out_frame][out_idx]));
                        errors++;
                    end
                    if (y_last !== (out_idx == OUT_PIX - 1)) begin
                        $display("FAIL y_last idx %0d: got %h expected %h",
                                 out_idx, y_last, out_idx == OUT_PIX - 1);
                        errors++;
                    end
                    if (capturing !== (out_frame == cap_frame)) begin
                        $display("FAIL capturing frame %0d: got %h expected %h",
                                 out_frame, capturing, out_frame == cap_frame);
                        errors++;
                    end
                    out_idx++;
                    if (out_idx == OUT_PIX) begin
                        out_idx = 0;
                        out_frame++;
                    end
                end
            end
        end
        trig_q <= capture_trigger;
    end

    // Watchdog
    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout, the edge stream did not finish in time");
        $display("Something failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        x_valid = 1'b0;
        x_data = '0;
        x_last = 1'b0;
        y_ready = 1'b0;
        capture_trigger = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_adr = '0;
        for (int t = 0; t < 9; t++) kernel[t] = '0;
        for (int f = 0; f < FRAMES; f++) make_frame(f);
        repeat (16) @(posedge clk);
        // Input side must refuse pixels while reset is held
        if (x_ready) begin
            $display("x_ready was high while reset was asserted");
            errors++;
        end
        rst <= 1'b0;
        repeat (2) @(posedge clk);
        if (y_valid || capturing || capture_complete || detection_valid || wb_ack) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        // Triggers land mid-frame in frames 1 and 3
        for (int f = 0; f < FRAMES; f++) drive_frame(f, f == 1 || f == 3);
        x_valid <= 1'b0;
        x_last  <= 1'b0;
        while (out_frame < FRAMES) @(posedge clk);
        repeat (4) @(posedge clk);
        if (cap_done != 2) begin
            $display("Expected two capture_complete pulses, saw %0d", cap_done);
            errors++;
        end
        if (!detection_valid) begin
            $display("detection_valid dropped without a trigger");
            errors++;
        end
        for (int a = 0; a < OUT_PIX; a++) wb_read(7'(a), 8'(exp_pix[4][a]));
        wb_read(7'(OUT_PIX), 8'h00);
        wb_read(7'h7f, 8'h00);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* design/pattern_recognition.sv */
`timescale 1ns/1ps

module pattern_recognition #(
    parameter int IMG_WIDTH    = 640,
    parameter int IMG_HEIGHT   = 480,
    parameter int W            = 8,
    parameter int W_FRAC       = 0,
    parameter int WHITE_THRESH = 128,
    parameter int MIN_WHITE    = 20
) (
    input  logic                clk,
    input  logic                rst,
    // Raw camera pixels
    input  logic                x_valid,
    output logic                x_ready,
    input  logic [W-1:0]        x_data,
    input  logic                x_last,
    // Edge image out
    output logic                y_valid,
    input  logic                y_ready,
    output logic [W-1:0]        y_data,
    output logic                y_last,
    // Row-major coefficients, stable per frame
    input  logic signed [W-1:0] kernel [0:vision_pkg::KERNEL_TAPS-1],
    // Capture control
    input  logic                capture_trigger,
    output logic                capture_complete,
    output logic                capturing,
    // Detection result
    output logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)+1)-1:0] white_count,
    output logic                crossing_detected,
    output logic                detection_valid,
    // Wishbone classic, read only
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] wb_adr,
    output logic [W-1:0]        wb_rdata,
    output logic                wb_ack
);

    pixel_stream_if #(.W(W)) in_s ();
    pixel_stream_if #(.W(W)) edge_s ();

    // Input ports into the sink stream
    assign in_s.valid = x_valid;
    assign in_s.data  = x_data;
    assign in_s.last  = x_last;
    assign x_ready    = in_s.ready;

    // Edge stream out to the y ports
    assign y_valid      = edge_s.valid;
    assign y_data       = edge_s.data;
    assign y_last       = edge_s.last;
    assign edge_s.ready = y_ready;

    convolution_filter #(
        .IMG_WIDTH (IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT),
        .W         (W),
        .W_FRAC    (W_FRAC)
    ) u_filter (
        .clk   (clk),
        .rst   (rst),
        .kernel(kernel),
        .x     (in_s),
        .y     (edge_s)
    );

    frame_capture #(
        .IMG_WIDTH   (IMG_WIDTH),
        .IMG_HEIGHT  (IMG_HEIGHT),
        .W           (W),
        .WHITE_THRESH(WHITE_THRESH),
        .MIN_WHITE   (MIN_WHITE)
    ) u_capture (
        .clk              (clk),
        .rst              (rst),
        .edge_px          (edge_s),
        .capture_trigger  (capture_trigger),
        .capture_complete (capture_complete),
        .capturing        (capturing),
        .white_count      (white_count),
        .crossing_detected(crossing_detected),
        .detection_valid  (detection_valid),
        .wb_cyc           (wb_cyc),
        .wb_stb           (wb_stb),
        .wb_adr           (wb_adr),
        .wb_rdata         (wb_rdata),
        .wb_ack           (wb_ack)
    );

endmodule

/* design/frame_capture.sv */
`timescale 1ns/1ps

module frame_capture #(
    parameter int IMG_WIDTH    = 640,
    parameter int IMG_HEIGHT   = 480,
    parameter int W            = 8,
    parameter int WHITE_THRESH = 128,
    parameter int MIN_WHITE    = 20
) (
    input  logic                   clk,
    input  logic                   rst,
    pixel_stream_if.monitor        edge_px,
    input  logic                   capture_trigger,
    output logic                   capture_complete,
    output logic                   capturing,
    output logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)+1)-1:0] white_count,
    output logic                   crossing_detected,
    output logic                   detection_valid,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic [$clog2((IMG_WIDTH-2)*(IMG_HEIGHT-2)):0] wb_adr,
    output logic [W-1:0]           wb_rdata,
    output logic                   wb_ack
);
    import vision_pkg::*;

    localparam int          FRAME_PIX = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);
    localparam int          FW        = $clog2(FRAME_PIX);
    localparam int          CNTW      = $clog2(FRAME_PIX + 1);
    localparam logic [FW:0] FRAME_END = (FW + 1)'(FRAME_PIX);

    logic [W-1:0]    frame_mem [0:FRAME_PIX-1];
    cap_state_e      state;
    logic            sof;
    logic            xfer;
    logic            white;
    logic            start;
    logic            take;
    logic            finish;
    logic [FW:0]     wr_addr;
    logic [FW:0]     wr_idx;
    logic [CNTW-1:0] cnt;
    logic [CNTW-1:0] cnt_next;

    assign xfer   = edge_px.valid && edge_px.ready;
    assign white  = edge_px.data >= W'(WHITE_THRESH);
    // First pixel of a frame while armed
    assign start  = (state == ARMED) && xfer && sof;
    assign take   = start || ((state == CAPTURE) && xfer);
    assign finish = take && edge_px.last;
    assign wr_idx = start ? '0 : wr_addr;
    assign cnt_next  = (start ? '0 : cnt) + CNTW'(white);
    assign capturing = (state == CAPTURE) || start;

    // ========================================
    // Capture FSM and white count
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            state             <= IDLE;
            sof               <= 1'b1;
            wr_addr           <= '0;
            cnt               <= '0;
            capture_complete  <= 1'b0;
            detection_valid   <= 1'b0;
            white_count       <= '0;
            crossing_detected <= 1'b0;
        end else begin
            capture_complete <= 1'b0;
            if (xfer) begin
                sof <= edge_px.last;
            end
            if (take) begin
                cnt     <= cnt_next;
                wr_addr <= wr_idx + 1'b1;
            end
            if (finish) begin
                state             <= DONE;
                capture_complete  <= 1'b1;
                detection_valid   <= 1'b1;
                white_count       <= cnt_next;
                crossing_detected <= cnt_next >= CNTW'(MIN_WHITE);
            end else if (start) begin
                state <= CAPTURE;
            end else if (capture_trigger && (state == IDLE || state == DONE)) begin
                state           <= ARMED;
                detection_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            frame_mem[wr_idx[FW-1:0]] <= edge_px.data;
        end
    end

    // ========================================
    // Wishbone read port
    // ========================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_cyc && wb_stb && !wb_ack;
        end
    end

    // Outside the frame reads zero
    always_ff @(posedge clk) begin
        if (wb_cyc && wb_stb && !wb_ack) begin
            wb_rdata <= (wb_adr < FRAME_END) ? frame_mem[wb_adr[FW-1:0]] : '0;
        end
    end

    // Classic cycle, the request is still up when its ack arrives
    assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb) && wb_cyc && wb_stb)
        else $error("wishbone ack without a held request");

    // Filter framing keeps writes inside the memory
    assert property (@(posedge clk) disable iff (rst)
        take |-> wr_idx < FRAME_END)
        else $error("capture write past frame end");

endmodule

/* design/convolution_filter.sv */
`timescale 1ns/1ps

module convolution_filter #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int W          = 8,
    parameter int W_FRAC     = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic signed [W-1:0] kernel [0:vision_pkg::KERNEL_TAPS-1],
    pixel_stream_if.sink        x,
    pixel_stream_if.source      y
);
    import vision_pkg::*;

    localparam int              AW      = acc_width(W);
    localparam int              OUT_PIX = (IMG_WIDTH - 2) * (IMG_HEIGHT - 2);
    localparam int              OCW     = $clog2(OUT_PIX);
    localparam logic [AW-1:0]   PIX_MAX = AW'((1 << W) - 1);

    logic [W-1:0]         win [0:KERNEL_SIZE-1][0:KERNEL_SIZE-1];
    logic                 win_valid;
    logic                 advance;
    logic signed [AW-1:0] prod [0:KERNEL_TAPS-1];
    logic                 s1_valid;
    logic signed [AW-1:0] acc;
    logic signed [AW-1:0] scaled;
    logic [AW-1:0]        magnitude;
    logic [W-1:0]         clamped;
    logic [OCW-1:0]       out_cnt;
    logic                 out_final;

    // Global stall, whole pipe moves or nothing moves
    // Held off while reset is active so the input is not accepted
    assign advance = !rst && (!y.valid || y.ready);

    line_window #(
        .IMG_WIDTH (IMG_WIDTH),
        .IMG_HEIGHT(IMG_HEIGHT),
        .W         (W)
    ) u_window (
        .clk      (clk),
        .rst      (rst),
        .px       (x),
        .advance  (advance),
        .win      (win),
        .win_valid(win_valid)
    );

    // ========================================
    // Stage 1 products
    // ========================================
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int t = 0; t < KERNEL_TAPS; t++) begin
                // Pixel is unsigned, zero bit in front
                prod[t] <= $signed(kernel[t])
                         * $signed({1'b0, win[t / KERNEL_SIZE][t % KERNEL_SIZE]});
            end
        end
    end

    // ========================================
    // Stage 2 sum, scale, clamp
    // ========================================
    always_comb begin
        acc = '0;
        for (int t = 0; t < KERNEL_TAPS; t++) begin
            acc = acc + prod[t];
        end
        scaled    = acc >>> W_FRAC;
        magnitude = scaled[AW-1] ? -scaled : scaled;
        // Saturate to full white
        clamped   = (magnitude > PIX_MAX) ? PIX_MAX[W-1:0] : magnitude[W-1:0];
    end

    assign out_final = (out_cnt == OCW'(OUT_PIX - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            y.valid  <= 1'b0;
            y.last   <= 1'b0;
            out_cnt  <= '0;
        end else if (advance) begin
            s1_valid <= win_valid;
            y.valid  <= s1_valid;
            if (s1_valid) begin
                y.last  <= out_final;
                out_cnt <= out_final ? '0 : out_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && s1_valid) begin
            y.data <= clamped;
        end
    end

    // Stalled output holds its beat
    assert property (@(posedge clk) disable iff (rst)
        y.valid && !y.ready |=> y.valid && $stable(y.data) && $stable(y.last))
        else $error("edge stream changed while stalled");

endmodule

/* design/line_window.sv */
`timescale 1ns/1ps

module line_window #(
    parameter int IMG_WIDTH  = 640,
    parameter int IMG_HEIGHT = 480,
    parameter int W          = 8
) (
    input  logic         clk,
    input  logic         rst,
    pixel_stream_if.sink px,
    input  logic         advance,
    output logic [W-1:0] win [0:vision_pkg::KERNEL_SIZE-1][0:vision_pkg::KERNEL_SIZE-1],
    output logic         win_valid
);
    import vision_pkg::*;

    localparam int CW = $clog2(IMG_WIDTH);
    localparam int RW = $clog2(IMG_HEIGHT);

    // Previous row (r-1) and the one before it (r-2)
    logic [W-1:0]  lb_near [0:IMG_WIDTH-1];
    logic [W-1:0]  lb_far  [0:IMG_WIDTH-1];
    // Two older window columns per row
    logic [W-1:0]  shift_q [0:KERNEL_SIZE-1][0:KERNEL_SIZE-2];
    // Newest column, top row first
    logic [W-1:0]  col_in  [0:KERNEL_SIZE-1];
    logic [CW-1:0] col;
    logic [RW-1:0] row;
    logic          accept;

    // Input only moves when the downstream pipe moves
    assign px.ready = advance;
    assign accept   = px.valid && advance;

    // Column under the incoming pixel
    assign col_in[0] = lb_far[col];
    assign col_in[1] = lb_near[col];
    assign col_in[2] = px.data;

    // Window is the shifted columns plus the live column
    always_comb begin
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE - 1; j++) begin
                win[i][j] = shift_q[i][j];
            end
            win[i][KERNEL_SIZE-1] = col_in[i];
        end
    end

    // Interior only, two rows and two columns already seen
    assign win_valid = px.valid && (row >= RW'(2)) && (col >= CW'(2));

    always_ff @(posedge clk) begin
        if (accept) begin
            // Rows move up one line buffer
            lb_far[col]  <= lb_near[col];
            lb_near[col] <= px.data;
            for (int i = 0; i < KERNEL_SIZE; i++) begin
                for (int j = 0; j < KERNEL_SIZE - 2; j++) begin
                    shift_q[i][j] <= shift_q[i][j+1];
                end
                shift_q[i][KERNEL_SIZE-2] <= col_in[i];
            end
        end
    end

    // Position tracking, last forces a fresh frame
    always_ff @(posedge clk) begin
        if (rst) begin
            col <= '0;
            row <= '0;
        end else if (accept) begin
            if (px.last) begin
                col <= '0;
                row <= '0;
            end else if (col == CW'(IMG_WIDTH - 1)) begin
                col <= '0;
                row <= (row == RW'(IMG_HEIGHT - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

endmodule

/* design/pixel_stream_if.sv */
`timescale 1ns/1ps

interface pixel_stream_if #(
    parameter int W = 8
);
    // Handshake pair
    logic         valid;
    logic         ready;
    // Pixel payload
    logic [W-1:0] data;
    // High on the final pixel of a frame
    logic         last;

    // Producer side
    modport source (output valid, output data, output last, input ready);

    // Consumer side
    modport sink (input valid, input data, input last, output ready);

    // Passive observer, never drives ready
    modport monitor (input valid, input ready, input data, input last);

endinterface

/* design/vision_pkg.sv */
package vision_pkg;

    // ========================================
    // Kernel geometry
    // ========================================

    // Side of the square kernel
    localparam int KERNEL_SIZE = 3;
    // Coefficient count, row-major order
    localparam int KERNEL_TAPS = KERNEL_SIZE * KERNEL_SIZE;

    // ========================================
    // Frame capture
    // ========================================

    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ARMED   = 2'd1,
        CAPTURE = 2'd2,
        DONE    = 2'd3
    } cap_state_e;

    // Signed accumulator width for w-bit pixels and coefficients
    // Each product fits in 2w signed bits, 4 guard bits cover nine terms
    function automatic int acc_width(input int w);
        return w + w + 4;
    endfunction

endpackage
